// ==== hw/exePkg.sv ====
package exePkg;

	// selects the execute path and how write-back data is formed
	typedef enum logic [2:0] {
		OP_ALU,
		OP_BRANCH,
		OP_LUI,
		OP_AUIPC,
		OP_JAL,
		OP_MULDIV,
		OP_CSR,
		OP_SYS
	} opClassT;

	// EQ, NE and LT are branch compares
	typedef enum logic [3:0] {
		ADD, SUB, AND, OR, XOR, SLT, SLTU, SLL, SRL, SRA, EQ, NE, LT
	} aluFnT;

	typedef enum logic [1:0] {MUL, MULHU, DIVU, REMU} mulOpT;
	typedef enum logic [1:0] {CSRRW = 2'd1, CSRRS = 2'd2, CSRRC = 2'd3} csrOpT;
	typedef enum logic {ECALL, ILLEGAL} sysOpT;
	typedef enum logic [1:0] {U = 2'd0, S = 2'd1, M = 2'd3} modeT;

	typedef struct packed {
		opClassT op;
		aluFnT aluFn;
		mulOpT mulOp;
		csrOpT csrOp;
		sysOpT sysOp;
		logic [4:0] rd;
		logic we;
		logic [31:0] opA;
		logic [31:0] opB;
		logic [31:0] imm;
		logic [31:0] pc;
		logic [11:0] csrAddr;
		logic [31:0] csrData; // current csr word
	} instrT;

	typedef struct packed {
		logic [4:0] rd;
		logic we;
		logic [31:0] data;
		logic [31:0] pc;
		logic taken;
		logic trap;
		logic [31:0] cause; // bit 31 flags an interrupt
		logic csrWe;
		logic [11:0] csrAddr;
		logic [31:0] csrNew;
	} resultT;

	localparam logic [30:0] M_INT_EXT = 31'd11;
	localparam logic [30:0] S_INT_EXT = 31'd9;
	localparam logic [30:0] M_INT_TIMER = 31'd7;
	localparam logic [30:0] S_INT_TIMER = 31'd5;
	localparam logic [30:0] U_CALL = 31'd8; // plus current mode
	localparam logic [30:0] I_ILLEGAL = 31'd2;

	localparam int IN_DEPTH = 4;
	localparam int RES_DEPTH = 2;
	localparam int OUT_CREDITS = 2;
	localparam int MD_STEPS = 32;

endpackage

// ==== hw/mulDivIf.sv ====
`timescale 1ns/1ps

// handshake between the control FSM and the iterative multiply/divide unit
interface mulDivIf ();
	import exePkg::*;

	logic start; // one cycle, only while not busy
	mulOpT op;
	logic [31:0] a;
	logic [31:0] b;

	logic busy;
	logic done; // one cycle pulse, res valid
	logic [31:0] res;

	modport ctrl (
		output start,
		output op,
		output a,
		output b,
		input busy,
		input done,
		input res
	);

	modport unit (
		input start,
		input op,
		input a,
		input b,
		output busy,
		output done,
		output res
	);

endinterface

// ==== hw/creditFifo.sv ====
`timescale 1ns/1ps

module creditFifo #(
	parameter type payloadT = exePkg::instrT
) (
	input logic clk,
	input logic nrst,
	input logic push,
	input payloadT pushData,
	output logic full,
	input logic pop,
	output payloadT popData,
	output logic empty
);
	import exePkg::*;

	// instruction entries get the deeper queue
	localparam int DEPTH = ($bits(payloadT) == $bits(instrT)) ? IN_DEPTH : RES_DEPTH;
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	payloadT mem [DEPTH];
	logic [PTR_W-1:0] wrPtr;
	logic [PTR_W-1:0] rdPtr;
	logic [CNT_W-1:0] count; // occupancy

	function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	always_ff @(posedge clk)
	begin
		if (push)
			mem[wrPtr] <= pushData;
	end

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (push)
				wrPtr <= nextPtr(wrPtr);
			if (pop)
				rdPtr <= nextPtr(rdPtr);
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

	assign full = (count == CNT_W'(DEPTH));
	assign empty = (count == '0);
	assign popData = mem[rdPtr]; // head entry, shown the cycle after its push

	noPushFull: assert property (@(posedge clk) disable iff (!nrst) !(push && full))
		else $error("creditFifo push while full");
	noPopEmpty: assert property (@(posedge clk) disable iff (!nrst) !(pop && empty))
		else $error("creditFifo pop while empty");

endmodule

// ==== hw/aluUnit.sv ====
`timescale 1ns/1ps

module aluUnit (
	input exePkg::aluFnT aluFn,
	input logic [31:0] a,
	input logic [31:0] b,
	input logic [31:0] pc,
	input logic [31:0] imm,
	output logic [31:0] res,
	output logic taken,
	output logic [31:0] target
);
	import exePkg::*;

	logic [4:0] shamt;

	assign shamt = b[4:0]; // low five bits only

	// branch compare
	always_comb
	begin
		case (aluFn)
			EQ: taken = (a == b);
			NE: taken = (a != b);
			LT: taken = ($signed(a) < $signed(b));
			default: taken = 1'b0;
		endcase
	end

	always_comb
	begin
		case (aluFn)
			ADD: res = a + b;
			SUB: res = a - b;
			AND: res = a & b;
			OR: res = a | b;
			XOR: res = a ^ b;
			SLT: res = {31'd0, $signed(a) < $signed(b)};
			SLTU: res = {31'd0, a < b};
			SLL: res = a << shamt;
			SRL: res = a >> shamt;
			SRA: res = 32'($signed(a) >>> shamt);
			EQ,
			NE,
			LT: res = {31'd0, taken};
			default: res = '0;
		endcase
	end

	assign target = pc + imm; // also the auipc value

endmodule

// ==== hw/mulDivUnit.sv ====
`timescale 1ns/1ps

module mulDivUnit (
	input logic clk,
	input logic nrst,
	mulDivIf.unit md
);
	import exePkg::*;

	localparam int CNT_W = $clog2(MD_STEPS + 1);

	logic [CNT_W-1:0] stepCnt;
	logic busyR;
	mulOpT opR;
	logic divZero;
	logic [32:0] hi; // partial product high half or remainder
	logic [31:0] lo; // multiplier bits or quotient bits
	logic [31:0] operand; // multiplicand or divisor
	logic isDiv;
	logic [32:0] addSum;
	logic [32:0] shifted;
	logic [33:0] diff;

	assign isDiv = (opR == DIVU) || (opR == REMU);
	assign addSum = {1'b0, hi[31:0]} + (lo[0] ? {1'b0, operand} : 33'd0);
	assign shifted = {hi[31:0], lo[31]};
	assign diff = {1'b0, shifted} - {2'b0, operand}; // trial subtract

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			busyR <= 1'b0;
			stepCnt <= '0;
		end
		else if (md.start)
		begin
			busyR <= 1'b1;
			stepCnt <= CNT_W'(MD_STEPS);
		end
		else if (busyR)
		begin
			if (stepCnt == '0)
				busyR <= 1'b0; // done cycle
			else
				stepCnt <= stepCnt - 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (md.start)
		begin
			opR <= md.op;
			divZero <= (md.b == '0);
			hi <= '0;
			lo <= md.a;
			operand <= md.b;
		end
		else if (busyR && stepCnt != '0)
		begin
			if (!isDiv)
			begin
				hi <= {1'b0, addSum[32:1]};
				lo <= {addSum[0], lo[31:1]};
			end
			else if (!diff[33])
			begin
				hi <= diff[32:0];
				lo <= {lo[30:0], 1'b1};
			end
			else
			begin
				hi <= shifted; // restore
				lo <= {lo[30:0], 1'b0};
			end
		end
	end

	assign md.busy = busyR;
	assign md.done = busyR && (stepCnt == '0);

	always_comb
	begin
		case (opR)
			MUL: md.res = lo;
			MULHU: md.res = hi[31:0];
			DIVU: md.res = divZero ? '1 : lo;
			default: md.res = hi[31:0]; // remu, dividend left over on zero divisor
		endcase
	end

	startIdle: assert property (@(posedge clk) disable iff (!nrst) md.start |-> !md.busy)
		else $error("mulDivUnit start while busy");

endmodule

// ==== hw/creditCounter.sv ====
`timescale 1ns/1ps

module creditCounter (
	input logic clk,
	input logic nrst,
	input logic send,
	input logic ret,
	output logic avail
);
	import exePkg::*;

	localparam int CNT_W = $clog2(OUT_CREDITS + 1);

	logic [CNT_W-1:0] count; // commit credits held

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
			count <= CNT_W'(OUT_CREDITS);
		else if (ret && !send)
			count <= count + 1'b1;
		else if (send && !ret)
			count <= count - 1'b1;
	end

	assign avail = (count != '0);

	noOverflow: assert property (@(posedge clk) disable iff (!nrst)
		ret && !send |-> count < CNT_W'(OUT_CREDITS))
		else $error("creditCounter credit returned above limit");
	noUnderflow: assert property (@(posedge clk) disable iff (!nrst) send |-> count != '0)
		else $error("creditCounter send with no credit");

endmodule

// ==== hw/trapUnit.sv ====
`timescale 1ns/1ps

module trapUnit (
	input exePkg::instrT instr,
	input exePkg::modeT mode,
	input logic mTimer,
	input logic sTimer,
	input logic extIrq,
	input logic mTie,
	input logic sTie,
	input logic mEie,
	input logic sEie,
	output logic trap,
	output logic [31:0] cause
);
	import exePkg::*;

	logic sLevel;
	logic mExt;
	logic sExt;
	logic mTim;
	logic sTim;
	logic isEcall;
	logic isIllegal;

	assign sLevel = (mode == U) || (mode == S); // supervisor irqs masked in M
	assign mExt = mEie && extIrq;
	assign sExt = sLevel && sEie && extIrq;
	assign mTim = mTie && mTimer;
	assign sTim = sLevel && sTie && sTimer;
	assign isEcall = (instr.op == OP_SYS) && (instr.sysOp == ECALL);
	assign isIllegal = (instr.op == OP_SYS) && (instr.sysOp == ILLEGAL);

	// interrupts first, then exceptions
	always_comb
	begin
		trap = 1'b1;
		cause = '0;
		if (mExt)
			cause = {1'b1, M_INT_EXT};
		else if (sExt)
			cause = {1'b1, S_INT_EXT};
		else if (mTim)
			cause = {1'b1, M_INT_TIMER};
		else if (sTim)
			cause = {1'b1, S_INT_TIMER};
		else if (isEcall)
			cause = {1'b0, U_CALL + 31'(mode)};
		else if (isIllegal)
			cause = {1'b0, I_ILLEGAL};
		else
			trap = 1'b0;
	end

endmodule

// ==== hw/exeControl.sv ====
`timescale 1ns/1ps

module exeControl (
	input logic clk,
	input logic nrst,
	input logic inEmpty,
	input exePkg::instrT inData,
	output logic inPop,
	input logic resFull,
	output logic resPush,
	output exePkg::resultT resData,
	mulDivIf.ctrl md,
	input exePkg::modeT mode,
	input logic mTimer,
	input logic sTimer,
	input logic extIrq,
	input logic mTie,
	input logic sTie,
	input logic mEie,
	input logic sEie
);
	import exePkg::*;

	typedef enum logic [1:0] {IDLE, MDWAIT, MDDONE} stateT;

	stateT state;
	resultT cur; // result formed in the pop cycle
	resultT mdRes; // held while mul/div runs
	logic [31:0] aluRes;
	logic [31:0] target;
	logic taken;
	logic trap;
	logic [31:0] cause;
	logic isMd;
	logic take;

	aluUnit alu (
		.aluFn(inData.aluFn),
		.a(inData.opA),
		.b(inData.opB),
		.pc(inData.pc),
		.imm(inData.imm),
		.res(aluRes),
		.taken(taken),
		.target(target)
	);

	trapUnit traps (
		.instr(inData),
		.mode(mode),
		.mTimer(mTimer),
		.sTimer(sTimer),
		.extIrq(extIrq),
		.mTie(mTie),
		.sTie(sTie),
		.mEie(mEie),
		.sEie(sEie),
		.trap(trap),
		.cause(cause)
	);

	assign isMd = (inData.op == OP_MULDIV);
	assign take = (state == IDLE) && !inEmpty;
	// single-cycle ops need room in the result queue
	assign inPop = take && (isMd ? !md.busy : !resFull);
	assign md.start = take && isMd && !md.busy;
	assign md.op = inData.mulOp;
	assign md.a = inData.opA;
	assign md.b = inData.opB;
	assign resPush = (take && !isMd && !resFull) || (state == MDDONE && !resFull);
	assign resData = (state == MDDONE) ? mdRes : cur;

	always_comb
	begin
		cur = '0;
		cur.rd = inData.rd;
		cur.pc = inData.pc;
		cur.trap = trap;
		cur.cause = cause;
		cur.csrAddr = inData.csrAddr;
		cur.we = inData.we && !trap;
		case (inData.op)
			OP_ALU: cur.data = aluRes;
			OP_BRANCH:
			begin
				cur.data = target;
				cur.taken = taken;
				cur.we = 1'b0;
			end
			OP_LUI: cur.data = inData.imm;
			OP_AUIPC: cur.data = target;
			OP_JAL: cur.data = inData.pc + 32'd4; // link value
			OP_CSR:
			begin
				cur.data = inData.csrData; // old value back to rd
				cur.csrWe = !trap;
				case (inData.csrOp)
					CSRRW: cur.csrNew = inData.opA;
					CSRRS: cur.csrNew = inData.csrData | inData.opA;
					CSRRC: cur.csrNew = inData.csrData & ~inData.opA;
					default: cur.csrNew = inData.csrData;
				endcase
			end
			default: cur.data = '0; // mul/div data arrives later
		endcase
	end

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
			state <= IDLE;
		else
		begin
			case (state)
				IDLE: if (md.start) state <= MDWAIT;
				MDWAIT: if (md.done) state <= MDDONE;
				MDDONE: if (!resFull) state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (md.start)
			mdRes <= cur; // trap sampled at pop
		else if (md.done && state == MDWAIT)
			mdRes.data <= md.res;
	end

	doneInWait: assert property (@(posedge clk) disable iff (!nrst) md.done |-> state == MDWAIT)
		else $error("exeControl mul/div done outside MDWAIT");

endmodule

// ==== hw/exeStage.sv ====
`timescale 1ns/1ps

module exeStage (
	input logic clk,
	input logic nrst,
	input logic issueValid,
	input exePkg::instrT issueData,
	output logic inCredit,
	output logic resValid,
	output exePkg::resultT resData,
	input logic resCredit,
	input exePkg::modeT mode,
	input logic mTimer,
	input logic sTimer,
	input logic extIrq,
	input logic mTie,
	input logic sTie,
	input logic mEie,
	input logic sEie
);
	import exePkg::*;

	instrT inData;
	logic inEmpty;
	logic inPop;
	resultT resIn;
	logic resPush;
	logic resFull;
	logic resEmpty;
	logic avail;

	mulDivIf mdBus ();

	// issue side fills it, one credit back per pop
	creditFifo #(.payloadT(instrT)) inFifo (
		.clk(clk),
		.nrst(nrst),
		.push(issueValid),
		.pushData(issueData),
		.full(),
		.pop(inPop),
		.popData(inData),
		.empty(inEmpty)
	);

	exeControl ctrl (
		.clk(clk),
		.nrst(nrst),
		.inEmpty(inEmpty),
		.inData(inData),
		.inPop(inPop),
		.resFull(resFull),
		.resPush(resPush),
		.resData(resIn),
		.md(mdBus),
		.mode(mode),
		.mTimer(mTimer),
		.sTimer(sTimer),
		.extIrq(extIrq),
		.mTie(mTie),
		.sTie(sTie),
		.mEie(mEie),
		.sEie(sEie)
	);

	mulDivUnit mulDiv (
		.clk(clk),
		.nrst(nrst),
		.md(mdBus)
	);

	creditFifo #(.payloadT(resultT)) resFifo (
		.clk(clk),
		.nrst(nrst),
		.push(resPush),
		.pushData(resIn),
		.full(resFull),
		.pop(resValid),
		.popData(resData),
		.empty(resEmpty)
	);

	creditCounter commitCredits (
		.clk(clk),
		.nrst(nrst),
		.send(resValid),
		.ret(resCredit),
		.avail(avail)
	);

	assign inCredit = inPop;
	assign resValid = !resEmpty && avail; // send only while a credit is held

endmodule

// ==== tests/exeStageTb.sv ====
`timescale 1ns/1ps

module exeStageTb;
	import exePkg::*;

	localparam int INSTR_TOTAL = 30 + 10 + 20 + 3 * 6 + 12 * 4 + 12;
	localparam int CYCLE_LIMIT = INSTR_TOTAL * (MD_STEPS + 8);

	logic clk;
	logic nrst;
	logic issueValid;
	instrT issueData;
	logic inCredit;
	logic resValid;
	resultT resData;
	logic resCredit;
	modeT mode;
	logic mTimer;
	logic sTimer;
	logic extIrq;
	logic mTie;
	logic sTie;
	logic mEie;
	logic sEie;

	resultT expQ [$]; // expected results in issue order
	resultT expHead; // result due at the next rising edge
	int toIssue;
	int kind;
	logic holdCredits;
	int issueCredits;
	int heldCredits; // commit credits the DUT holds
	int issued;
	int creditPulses;
	int received;
	int errCount;
	int testCount;
	int cycles;

	exeStage exeStage_inst (
		.clk(clk),
		.nrst(nrst),
		.issueValid(issueValid),
		.issueData(issueData),
		.inCredit(inCredit),
		.resValid(resValid),
		.resData(resData),
		.resCredit(resCredit),
		.mode(mode),
		.mTimer(mTimer),
		.sTimer(sTimer),
		.extIrq(extIrq),
		.mTie(mTie),
		.sTie(sTie),
		.mEie(mEie),
		.sEie(sEie)
	);

	task automatic reportMismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		$display("Error: %s got 0x%h expected 0x%h", name, got, exp);
		errCount++;
	endtask

	task automatic reportFailure(input string msg);
		$display("%s", msg);
		errCount++;
	endtask

	function automatic modeT pickMode();
		int r;
		r = $urandom_range(2);
		return (r == 0) ? U : (r == 1) ? S : M;
	endfunction

	// kind 0 alu mix, 1 mul/div, 2 csr, 3 sys, 4 any of 0, 2 and 3
	function automatic instrT makeInstr(input int sel);
		instrT i;
		int k;
		int r;
		k = sel;
		if (k == 4)
		begin
			r = $urandom_range(2);
			k = (r == 0) ? 0 : (r == 1) ? 2 : 3;
		end
		i = '0;
		i.rd = 5'($urandom);
		i.we = 1'($urandom);
		i.opA = $urandom;
		i.opB = $urandom;
		i.imm = $urandom;
		i.pc = $urandom & 32'hffff_fffc;
		i.csrAddr = 12'($urandom);
		i.csrData = $urandom;
		case (k)
			0:
			begin
				r = $urandom_range(4);
				i.op = (r == 0) ? OP_ALU : (r == 1) ? OP_BRANCH : (r == 2) ? OP_LUI :
					(r == 3) ? OP_AUIPC : OP_JAL;
				i.aluFn = aluFnT'(4'($urandom_range(9)));
				if (i.op == OP_BRANCH)
				begin
					i.aluFn = aluFnT'(4'(10 + $urandom_range(2)));
					if ($urandom_range(1) == 0)
						i.opB = i.opA; // make equal compares happen
				end
			end
			1:
			begin
				i.op = OP_MULDIV;
				i.mulOp = mulOpT'(2'($urandom_range(3)));
				if ($urandom_range(3) == 0)
					i.opB = 32'd0;
				else if ($urandom_range(1) == 0)
					i.opB = i.opB >> $urandom_range(31); // small divisors
			end
			2:
			begin
				i.op = OP_CSR;
				i.csrOp = csrOpT'(2'(1 + $urandom_range(2)));
			end
			default:
			begin
				i.op = OP_SYS;
				i.sysOp = sysOpT'(1'($urandom_range(1)));
			end
		endcase
		return i;
	endfunction

	// reference model, uses mode and interrupt lines as they stand at issue
	function automatic resultT expectResult(input instrT i);
		resultT r;
		logic [63:0] prod;
		r = '0;
		r.rd = i.rd;
		r.pc = i.pc;
		r.csrAddr = i.csrAddr;
		if (mEie && extIrq)
			r.cause = {1'b1, 31'd11};
		else if (mode != M && sEie && extIrq)
			r.cause = {1'b1, 31'd9};
		else if (mTie && mTimer)
			r.cause = {1'b1, 31'd7};
		else if (mode != M && sTie && sTimer)
			r.cause = {1'b1, 31'd5};
		else if (i.op == OP_SYS && i.sysOp == ECALL)
			r.cause = 32'd8 + 32'(mode);
		else if (i.op == OP_SYS)
			r.cause = 32'd2;
		r.trap = (r.cause != 32'd0);
		case (i.op)
			OP_ALU:
				case (i.aluFn)
					ADD: r.data = i.opA + i.opB;
					SUB: r.data = i.opA - i.opB;
					AND: r.data = i.opA & i.opB;
					OR: r.data = i.opA | i.opB;
					XOR: r.data = i.opA ^ i.opB;
					SLT: r.data = ($signed(i.opA) < $signed(i.opB)) ? 32'd1 : 32'd0;
					SLTU: r.data = (i.opA < i.opB) ? 32'd1 : 32'd0;
					SLL: r.data = i.opA << i.opB[4:0];
					SRL: r.data = i.opA >> i.opB[4:0];
					SRA: r.data = $unsigned($signed(i.opA) >>> i.opB[4:0]);
					default: r.data = 32'd0;
				endcase
			OP_BRANCH:
			begin
				r.data = i.pc + i.imm;
				r.taken = (i.aluFn == EQ) ? (i.opA == i.opB) : (i.aluFn == NE) ?
					(i.opA != i.opB) : ($signed(i.opA) < $signed(i.opB));
			end
			OP_LUI: r.data = i.imm;
			OP_AUIPC: r.data = i.pc + i.imm;
			OP_JAL: r.data = i.pc + 32'd4;
			OP_MULDIV:
			begin
				prod = {32'd0, i.opA} * {32'd0, i.opB};
				case (i.mulOp)
					MUL: r.data = prod[31:0];
					MULHU: r.data = prod[63:32];
					DIVU: r.data = (i.opB == 32'd0) ? 32'hffff_ffff : i.opA / i.opB;
					default: r.data = (i.opB == 32'd0) ? i.opA : i.opA % i.opB;
				endcase
			end
			OP_CSR:
			begin
				r.data = i.csrData;
				r.csrWe = !r.trap;
				case (i.csrOp)
					CSRRW: r.csrNew = i.opA;
					CSRRS: r.csrNew = i.csrData | i.opA;
					default: r.csrNew = i.csrData & ~i.opA;
				endcase
			end
			default: r.data = 32'd0;
		endcase
		r.we = i.we && !r.trap && (i.op != OP_BRANCH);
		return r;
	endfunction

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycles > CYCLE_LIMIT)
		begin
			$display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Result: FAILED");
			$finish;
		end
	end

	always @(posedge clk or negedge nrst)
	begin
		if (!nrst)
			heldCredits <= OUT_CREDITS;
		else
			heldCredits <= heldCredits - int'(resValid) + int'(resCredit);
	end

	// issuer, commit side and model bookkeeping, all on the falling edge
	always @(negedge clk)
	begin
		if (nrst)
		begin
			resCredit = !holdCredits && heldCredits < OUT_CREDITS && ($urandom_range(2) == 0);
			if (resValid)
			begin
				if (expQ.size() == 0)
					reportFailure("a result was sent with no instruction outstanding");
				else
					expHead = expQ.pop_front();
				received++;
			end
			issueValid = 1'b0;
			if (toIssue > 0 && issueCredits > 0 && $urandom_range(3) != 0)
			begin
				issueData = makeInstr(kind);
				expQ.push_back(expectResult(issueData));
				issueValid = 1'b1;
				issueCredits--;
				toIssue--;
				issued++;
			end
			if (inCredit)
			begin
				issueCredits++; // usable from the next cycle
				creditPulses++;
			end
			assert (issueCredits <= IN_DEPTH)
				else reportMismatch("issue credits", 32'(issueCredits), 32'(IN_DEPTH));
		end
	end

	checkData: assert property (@(posedge clk) disable iff (!nrst)
		resValid |-> resData.data == expHead.data)
		else reportMismatch("resData.data", $sampled(resData.data), expHead.data);
	checkWe: assert property (@(posedge clk) disable iff (!nrst)
		resValid |-> resData.we == expHead.we)
		else reportMismatch("resData.we", 32'($sampled(resData.we)), 32'(expHead.we));
	checkTaken: assert property (@(posedge clk) disable iff (!nrst)
		resValid |-> resData.taken == expHead.taken)
		else reportMismatch("resData.taken", 32'($sampled(resData.taken)), 32'(expHead.taken));
	checkTrap: assert property (@(posedge clk) disable iff (!nrst)
		resValid |-> resData.trap == expHead.trap)
		else reportMismatch("resData.trap", 32'($sampled(resData.trap)), 32'(expHead.trap));
	checkCause: assert property (@(posedge clk) disable iff (!nrst)
		resValid |-> resData.cause == expHead.cause)
		else reportMismatch("resData.cause", $sampled(resData.cause), expHead.cause);
	checkCsrWe: assert property (@(posedge clk) disable iff (!nrst)
		resValid |-> resData.csrWe == expHead.csrWe)
		else reportMismatch("resData.csrWe", 32'($sampled(resData.csrWe)), 32'(expHead.csrWe));
	checkCsrNew: assert property (@(posedge clk) disable iff (!nrst)
		resValid |-> resData.csrNew == expHead.csrNew)
		else reportMismatch("resData.csrNew", $sampled(resData.csrNew), expHead.csrNew);
	checkRd: assert property (@(posedge clk) disable iff (!nrst)
		resValid |-> resData.rd == expHead.rd)
		else reportMismatch("resData.rd", 32'($sampled(resData.rd)), 32'(expHead.rd));
	checkPc: assert property (@(posedge clk) disable iff (!nrst)
		resValid |-> resData.pc == expHead.pc)
		else reportMismatch("resData.pc", $sampled(resData.pc), expHead.pc);
	checkCsrAddr: assert property (@(posedge clk) disable iff (!nrst)
		resValid |-> resData.csrAddr == expHead.csrAddr)
		else reportMismatch("resData.csrAddr", 32'($sampled(resData.csrAddr)),
			32'(expHead.csrAddr));
	creditHeld: assert property (@(posedge clk) disable iff (!nrst)
		resValid |-> heldCredits > 0)
		else reportFailure("a result was sent while the DUT held no commit credit");

	// hands a batch to the issuer and waits until every result is back
	task automatic issueBatch(input int k, input int count, input int holdCycles);
		kind = k;
		holdCredits = (holdCycles > 0);
		toIssue = count;
		repeat (holdCycles) @(negedge clk);
		holdCredits = 1'b0;
		while (toIssue > 0 || expQ.size() > 0)
			@(negedge clk);
	endtask

	task automatic endTest(input string name, input int errBefore);
		@(posedge clk); // last result checked here
		@(negedge clk);
		assert (creditPulses == issued)
			else reportMismatch("inCredit pulses", 32'(creditPulses), 32'(issued));
		testCount++;
		$display("test %0d %s done, %0d errors", testCount, name, errCount - errBefore);
	endtask

	initial
	begin
		int errStart;
		void'($urandom(66));
		nrst = 1'b0;
		issueValid = 1'b0;
		issueData = '0;
		resCredit = 1'b0;
		mode = M;
		{mTimer, sTimer, extIrq, mTie, sTie, mEie, sEie} = 7'd0;
		expHead = '0;
		holdCredits = 1'b0;
		issueCredits = IN_DEPTH;
		repeat (2) @(posedge clk);
		@(negedge clk);
		nrst = 1'b1;
		errStart = errCount;
		issueBatch(0, 30, 0);
		endTest("alu, lui, auipc, jal and branch", errStart);
		errStart = errCount;
		issueBatch(1, 10, 0);
		endTest("multiply and divide", errStart);
		errStart = errCount;
		issueBatch(2, 20, 0);
		endTest("csr read-modify-write", errStart);
		errStart = errCount;
		for (int m = 0; m < 3; m++)
		begin
			mode = (m == 0) ? U : (m == 1) ? S : M;
			issueBatch(3, 6, 0);
		end
		endTest("ecall and illegal", errStart);
		errStart = errCount;
		for (int p = 0; p < 12; p++)
		begin
			mode = pickMode();
			{mTimer, sTimer, extIrq, mTie, sTie, mEie, sEie} = 7'($urandom);
			issueBatch(4, 4, 0);
		end
		mode = M;
		{mTimer, sTimer, extIrq, mTie, sTie, mEie, sEie} = 7'd0;
		endTest("gated interrupts", errStart);
		errStart = errCount;
		issueBatch(0, 12, 30); // credits withheld, queues fill up
		endTest("commit credit back-pressure", errStart);
		$display("%0d tests, %0d results, %0d errors", testCount, received, errCount);
		if (errCount == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

// ==== filelist.f ====
hw/exePkg.sv
hw/mulDivIf.sv
hw/creditFifo.sv
hw/aluUnit.sv
hw/mulDivUnit.sv
hw/creditCounter.sv
hw/trapUnit.sv
hw/exeControl.sv
hw/exeStage.sv
tests/exeStageTb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the exeStage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 --top-module exeStageTb -f filelist.f -o exeStageSim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/exeStageSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^Result: PASSED$" sim.log; then
	exit 0
fi
exit 1
